// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_mips_datapath
FILELIST = filelist.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST PASS" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== design/alu.sv ====
`timescale 1ns/100ps

module alu
    import mips_isa_pkg::*, mips_pipe_pkg::*;
(
    input  alu_op_e i_alu_op,
    input  word_t   i_data_a,
    input  word_t   i_data_b,
    output word_t   o_result
);

    logic less_than;

    // Signed compare for slt and slti.
    assign less_than = $signed(i_data_a) < $signed(i_data_b);

    always_comb begin
        case (i_alu_op)
            ALU_AND: begin
                o_result = i_data_a & i_data_b;
            end
            ALU_OR: begin
                o_result = i_data_a | i_data_b;
            end
            ALU_ADD: begin
                o_result = i_data_a + i_data_b;
            end
            ALU_SUB: begin
                o_result = i_data_a - i_data_b;
            end
            ALU_SLT: begin
                o_result = word_t'(less_than);
            end
            ALU_NOR: begin
                o_result = ~(i_data_a | i_data_b);
            end
            default: begin
                o_result = '0;
            end
        endcase
    end

endmodule

// ==== design/instruction_decode.sv ====
`timescale 1ns/100ps

module instruction_decode
    import mips_isa_pkg::*, mips_pipe_pkg::*;
(
    input  logic   i_clock,
    input  logic   i_soft_reset,
    input  logic   i_enable_pipeline,
    input  logic   i_instr_valid,
    input  instr_t i_instr,
    input  wb_t    i_wb,
    output id_ex_t o_id_ex
);

    localparam int EXT_BITS = $bits(word_t) - $bits(imm_t);

    r_instr_t r_fields;
    i_instr_t i_fields;
    ex_ctrl_t ctrl;
    logic     id_valid;
    logic     zero_ext;
    word_t    imm_ext;
    word_t    rd_data_a;
    word_t    rd_data_b;

    assign r_fields = r_instr_t'(i_instr);
    assign i_fields = i_instr_t'(i_instr);

    //////////////////////////////
    // Control decode.
    //////////////////////////////
    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;
        id_valid    = i_instr_valid;
        zero_ext    = 1'b0;
        case (r_fields.opcode)
            R_TYPE: begin
                ctrl.reg_dst   = 1'b1;
                ctrl.reg_write = 1'b1;
                case (r_fields.funct)
                    ADD:     ctrl.alu_op = ALU_ADD;
                    SUB:     ctrl.alu_op = ALU_SUB;
                    AND:     ctrl.alu_op = ALU_AND;
                    OR:      ctrl.alu_op = ALU_OR;
                    NOR:     ctrl.alu_op = ALU_NOR;
                    SLT:     ctrl.alu_op = ALU_SLT;
                    default: id_valid = 1'b0;
                endcase
            end
            ADDI: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            SLTI: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_SLT;
            end
            ANDI, ORI: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = (r_fields.opcode == ANDI) ? ALU_AND : ALU_OR;
                zero_ext       = 1'b1;
            end
            LW: begin
                ctrl.alu_src    = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            SW: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            default: id_valid = 1'b0;
        endcase
        // A bubble carries no side effects.
        if (!id_valid) begin
            ctrl = '0;
        end
    end

    // Logic ops take the immediate unsigned.
    assign imm_ext = zero_ext ? {{EXT_BITS{1'b0}}, i_fields.imm}
                              : {{EXT_BITS{i_fields.imm[15]}}, i_fields.imm};

    register_file u_register_file (
        .i_clock      (i_clock),
        .i_soft_reset (i_soft_reset),
        .i_rd_idx_a   (i_fields.rs),
        .i_rd_idx_b   (i_fields.rt),
        .i_wr_en      (i_wb.valid & i_enable_pipeline),
        .i_wr_idx     (i_wb.dest),
        .i_wr_data    (i_wb.data),
        .o_rd_data_a  (rd_data_a),
        .o_rd_data_b  (rd_data_b)
    );

    always_ff @(posedge i_clock) begin
        if (~i_soft_reset) begin
            o_id_ex <= '0;
        end else if (i_enable_pipeline) begin
            o_id_ex.valid   <= id_valid;
            o_id_ex.ctrl    <= ctrl;
            o_id_ex.data_a  <= rd_data_a;
            o_id_ex.data_b  <= rd_data_b;
            o_id_ex.imm_ext <= imm_ext;
            o_id_ex.rt      <= r_fields.rt;
            o_id_ex.rd      <= r_fields.rd;
        end
    end

endmodule

// ==== design/memory_writeback.sv ====
`timescale 1ns/100ps

`include "mips_cfg.svh"

module memory_writeback
    import mips_isa_pkg::*, mips_pipe_pkg::*;
#(
    parameter int DEPTH_WORDS = `MIPS_DMEM_DEPTH
)
(
    input  logic    i_clock,
    input  logic    i_soft_reset,
    input  logic    i_enable_pipeline,
    input  ex_mem_t i_ex_mem,
    output wb_t     o_wb
);

    localparam int ADDR_BITS = $clog2(DEPTH_WORDS);

    word_t                  mem [DEPTH_WORDS];
    logic [ADDR_BITS - 1:0] addr;
    word_t                  load_data;
    logic                   store_en;

    // Word address that wraps modulo the depth.
    assign addr      = i_ex_mem.result[ADDR_BITS + 1 : 2];
    assign load_data = i_ex_mem.mem_read ? mem[addr] : '0;
    assign store_en  = i_ex_mem.valid & i_ex_mem.mem_write;

    //////////////////////////////
    // Data memory.
    //////////////////////////////
    always_ff @(posedge i_clock) begin
        if (~i_soft_reset) begin
            for (int i = 0; i < DEPTH_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (i_enable_pipeline && store_en) begin
            mem[addr] <= i_ex_mem.store_data;
        end
    end

    //////////////////////////////
    // MEM/WB register.
    //////////////////////////////
    always_ff @(posedge i_clock) begin
        if (~i_soft_reset) begin
            o_wb <= '0;
        end else if (i_enable_pipeline) begin
            // Writes to register zero are dropped here.
            o_wb.valid <= i_ex_mem.valid & i_ex_mem.reg_write & (i_ex_mem.dest != '0);
            o_wb.dest  <= i_ex_mem.dest;
            o_wb.data  <= i_ex_mem.mem_to_reg ? load_data : i_ex_mem.result;
        end
    end

endmodule

// ==== design/mips_cfg.svh ====
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// Datapath word width in bits.
`define MIPS_DATA_WIDTH 32

// Number of general purpose registers.
`define MIPS_REG_COUNT 32

// Instruction word width in bits.
`define MIPS_INSTR_WIDTH 32

// Width of the ALU control code.
`define MIPS_ALU_CTRL_WIDTH 4

// Data memory depth in words as a power of two.
`define MIPS_DMEM_DEPTH 64

`endif

// ==== design/mips_datapath_top.sv ====
`timescale 1ns/100ps

`include "mips_cfg.svh"

module mips_datapath_top
    import mips_isa_pkg::*, mips_pipe_pkg::*;
(
    input  logic     i_clock,
    input  logic     i_soft_reset,
    input  logic     i_enable_pipeline,
    input  logic     i_instr_valid,
    input  instr_t   i_instr,
    output logic     o_wb_valid,
    output reg_idx_t o_wb_reg,
    output word_t    o_wb_data,
    output logic     o_store_valid,
    output word_t    o_store_addr,
    output word_t    o_store_data
);

    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    wb_t     wb;

    instruction_decode u_instruction_decode (
        .i_clock           (i_clock),
        .i_soft_reset      (i_soft_reset),
        .i_enable_pipeline (i_enable_pipeline),
        .i_instr_valid     (i_instr_valid),
        .i_instr           (i_instr),
        .i_wb              (wb),
        .o_id_ex           (id_ex)
    );

    top_execute u_top_execute (
        .i_clock           (i_clock),
        .i_soft_reset      (i_soft_reset),
        .i_enable_pipeline (i_enable_pipeline),
        .i_id_ex           (id_ex),
        .o_ex_mem          (ex_mem)
    );

    memory_writeback #(
        .DEPTH_WORDS (`MIPS_DMEM_DEPTH)
    ) u_memory_writeback (
        .i_clock           (i_clock),
        .i_soft_reset      (i_soft_reset),
        .i_enable_pipeline (i_enable_pipeline),
        .i_ex_mem          (ex_mem),
        .o_wb              (wb)
    );

    // Writeback port.
    assign o_wb_valid = wb.valid;
    assign o_wb_reg   = wb.dest;
    assign o_wb_data  = wb.data;

    // The store port shows the store while it sits in EX/MEM.
    assign o_store_valid = ex_mem.valid & ex_mem.mem_write;
    assign o_store_addr  = ex_mem.result;
    assign o_store_data  = ex_mem.store_data;

endmodule

// ==== design/mips_isa_pkg.sv ====
package mips_isa_pkg;

    `include "mips_cfg.svh"

    //////////////////////////////
    // Basic widths.
    //////////////////////////////
    typedef logic [`MIPS_DATA_WIDTH - 1 : 0]         word_t;
    typedef logic [$clog2(`MIPS_REG_COUNT) - 1 : 0] reg_idx_t;
    typedef logic [15 : 0]                          imm_t;
    typedef logic [`MIPS_INSTR_WIDTH - 1 : 0]       instr_t;

    // R-format field layout.
    typedef struct packed {
        logic [5 : 0] opcode;
        reg_idx_t     rs;
        reg_idx_t     rt;
        reg_idx_t     rd;
        logic [4 : 0] shamt;
        logic [5 : 0] funct;
    } r_instr_t;

    // I-format field layout.
    typedef struct packed {
        logic [5 : 0] opcode;
        reg_idx_t     rs;
        reg_idx_t     rt;
        imm_t         imm;
    } i_instr_t;

    //////////////////////////////
    // Encodings.
    //////////////////////////////
    typedef enum logic [5 : 0] {
        R_TYPE = 6'h00,
        ADDI   = 6'h08,
        SLTI   = 6'h0A,
        ANDI   = 6'h0C,
        ORI    = 6'h0D,
        LW     = 6'h23,
        SW     = 6'h2B
    } opcode_e;

    // Function field of R-type words.
    typedef enum logic [5 : 0] {
        ADD = 6'h20,
        SUB = 6'h22,
        AND = 6'h24,
        OR  = 6'h25,
        NOR = 6'h27,
        SLT = 6'h2A
    } funct_e;

endpackage

// ==== design/mips_pipe_pkg.sv ====
package mips_pipe_pkg;

    `include "mips_cfg.svh"

    import mips_isa_pkg::*;

    // Classic MIPS ALU control codes.
    typedef enum logic [`MIPS_ALU_CTRL_WIDTH - 1 : 0] {
        ALU_AND = 4'b0000,
        ALU_OR  = 4'b0001,
        ALU_ADD = 4'b0010,
        ALU_SUB = 4'b0110,
        ALU_SLT = 4'b0111,
        ALU_NOR = 4'b1100
    } alu_op_e;

    //////////////////////////////
    // Stage control.
    //////////////////////////////
    typedef struct packed {
        logic    reg_dst;
        logic    alu_src;
        alu_op_e alu_op;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
    } ex_ctrl_t;

    //////////////////////////////
    // Stage registers.
    //////////////////////////////
    typedef struct packed {
        logic     valid;
        ex_ctrl_t ctrl;
        word_t    data_a;
        word_t    data_b;
        word_t    imm_ext;
        reg_idx_t rt;
        reg_idx_t rd;
    } id_ex_t;

    // Execute results with the controls left for memory and writeback.
    typedef struct packed {
        logic     valid;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     mem_to_reg;
        word_t    result;
        word_t    store_data;
        reg_idx_t dest;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t dest;
        word_t    data;
    } wb_t;

endpackage

// ==== design/register_file.sv ====
`timescale 1ns/100ps

`include "mips_cfg.svh"

module register_file
    import mips_isa_pkg::*;
(
    input  logic     i_clock,
    input  logic     i_soft_reset,
    input  reg_idx_t i_rd_idx_a,
    input  reg_idx_t i_rd_idx_b,
    input  logic     i_wr_en,
    input  reg_idx_t i_wr_idx,
    input  word_t    i_wr_data,
    output word_t    o_rd_data_a,
    output word_t    o_rd_data_b
);

    word_t regs [`MIPS_REG_COUNT];

    // Register zero reads zero and a same-cycle write passes through.
    function automatic word_t read_port(input reg_idx_t idx);
        word_t value;
        if (idx == '0) begin
            value = '0;
        end else if (i_wr_en && (idx == i_wr_idx)) begin
            value = i_wr_data;
        end else begin
            value = regs[idx];
        end
        return value;
    endfunction

    always_ff @(posedge i_clock) begin
        if (~i_soft_reset) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en) begin
            regs[i_wr_idx] <= i_wr_data;
        end
    end

    always_comb begin
        o_rd_data_a = read_port(i_rd_idx_a);
        o_rd_data_b = read_port(i_rd_idx_b);
    end

endmodule

// ==== design/top_execute.sv ====
`timescale 1ns/100ps

module top_execute
    import mips_isa_pkg::*, mips_pipe_pkg::*;
(
    input  logic    i_clock,
    input  logic    i_soft_reset,
    input  logic    i_enable_pipeline,
    input  id_ex_t  i_id_ex,
    output ex_mem_t o_ex_mem
);

    reg_idx_t dest;
    word_t    operand_b;
    word_t    alu_result;

    //////////////////////////////
    // Operand and destination.
    //////////////////////////////

    // R-type writes rd, I-type writes rt.
    assign dest = i_id_ex.ctrl.reg_dst ? i_id_ex.rd : i_id_ex.rt;

    // Register or extended immediate.
    assign operand_b = i_id_ex.ctrl.alu_src ? i_id_ex.imm_ext : i_id_ex.data_b;

    alu u_alu (
        .i_alu_op (i_id_ex.ctrl.alu_op),
        .i_data_a (i_id_ex.data_a),
        .i_data_b (operand_b),
        .o_result (alu_result)
    );

    //////////////////////////////
    // EX/MEM register.
    //////////////////////////////
    always_ff @(posedge i_clock) begin
        if (~i_soft_reset) begin
            o_ex_mem <= '0;
        end else if (i_enable_pipeline) begin
            o_ex_mem.valid      <= i_id_ex.valid;
            o_ex_mem.reg_write  <= i_id_ex.ctrl.reg_write;
            o_ex_mem.mem_read   <= i_id_ex.ctrl.mem_read;
            o_ex_mem.mem_write  <= i_id_ex.ctrl.mem_write;
            o_ex_mem.mem_to_reg <= i_id_ex.ctrl.mem_to_reg;
            o_ex_mem.result     <= alu_result;
            // Stores take the rt operand.
            o_ex_mem.store_data <= i_id_ex.data_b;
            o_ex_mem.dest       <= dest;
        end
    end

endmodule

// ==== filelist.f ====
+incdir+design
design/mips_isa_pkg.sv
design/mips_pipe_pkg.sv
design/register_file.sv
design/alu.sv
design/instruction_decode.sv
design/top_execute.sv
design/memory_writeback.sv
design/mips_datapath_top.sv
tb/tb_mips_datapath.sv

// ==== tb/tb_mips_datapath.sv ====
`timescale 1ns/100ps

`include "mips_cfg.svh"

module tb_mips_datapath
    import mips_isa_pkg::*;
();

    localparam int ADDR_BITS = $clog2(`MIPS_DMEM_DEPTH);
    // Enabled edges from the accepting edge to the edge that shows the result.
    localparam int WB_DELAY    = 2;
    localparam int STORE_DELAY = 1;
    localparam int DRAIN_LIMIT = 40;
    localparam logic [15:0] LFSR_SEED = 16'd58877;

    typedef enum logic [1:0] {KIND_NONE, KIND_WB, KIND_STORE} kind_e;

    typedef struct {
        instr_t   instr;
        logic     valid;
        logic     enable;
        kind_e    kind;
        reg_idx_t exp_reg;
        word_t    exp_val;
        word_t    exp_data;
    } row_t;

    typedef struct {
        reg_idx_t dest;
        word_t    data;
        int       edge_idx;
    } wb_exp_t;

    typedef struct {
        word_t addr;
        word_t data;
        int    edge_idx;
    } store_exp_t;

    logic     clock = 1'b0;
    logic     soft_reset;
    logic     enable_pipeline;
    logic     instr_valid;
    instr_t   instr;
    logic     wb_valid;
    reg_idx_t wb_reg;
    word_t    wb_data;
    logic     store_valid;
    word_t    store_addr;
    word_t    store_data;

    row_t       rows[$];
    wb_exp_t    wb_q[$];
    store_exp_t store_q[$];
    wb_exp_t    wb_head;
    store_exp_t store_head;
    word_t      model_regs [`MIPS_REG_COUNT];
    word_t      model_mem [`MIPS_DMEM_DEPTH];
    logic [15:0] lfsr_state;
    int         cur_row;
    int         edge_count;
    logic       last_enabled;
    int         wait_cycles;
    int         wb_errors;
    int         store_errors;
    int         latency_errors;
    int         missing_errors;

    always #10 clock = ~clock;

    mips_datapath_top i_dut (
        .i_clock           (clock),
        .i_soft_reset      (soft_reset),
        .i_enable_pipeline (enable_pipeline),
        .i_instr_valid     (instr_valid),
        .i_instr           (instr),
        .o_wb_valid        (wb_valid),
        .o_wb_reg          (wb_reg),
        .o_wb_data         (wb_data),
        .o_store_valid     (store_valid),
        .o_store_addr      (store_addr),
        .o_store_data      (store_data)
    );

    //////////////////////////////
    // Stimulus helpers.
    //////////////////////////////

    // Taps 16, 14, 13 and 11.
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic next_random_imm(output imm_t value);
        for (int i = 0; i < 16; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value[i] = lfsr_state[0];
        end
    endtask

    function automatic instr_t encode_r(input logic [5:0] funct, input reg_idx_t rs,
                                        input reg_idx_t rt, input reg_idx_t rd);
        return {R_TYPE, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic instr_t encode_i(input logic [5:0] opcode, input reg_idx_t rs,
                                        input reg_idx_t rt, input imm_t imm);
        return {opcode, rs, rt, imm};
    endfunction

    function automatic word_t sign_ext(input imm_t imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic word_t zero_ext(input imm_t imm);
        return {16'h0000, imm};
    endfunction

    //////////////////////////////
    // Reference model.
    //////////////////////////////
    task automatic model_exec(input instr_t word, output row_t row);
        reg_idx_t rs;
        reg_idx_t rt;
        word_t    a;
        word_t    b;
        word_t    addr;
        rs = word[25:21];
        rt = word[20:16];
        a = model_regs[rs];
        b = model_regs[rt];
        row.kind = KIND_WB;
        row.exp_reg = rt;
        row.exp_val = '0;
        row.exp_data = '0;
        addr = a + sign_ext(word[15:0]);
        case (word[31:26])
            R_TYPE: begin
                row.exp_reg = word[15:11];
                case (word[5:0])
                    ADD:     row.exp_val = a + b;
                    SUB:     row.exp_val = a - b;
                    AND:     row.exp_val = a & b;
                    OR:      row.exp_val = a | b;
                    NOR:     row.exp_val = ~(a | b);
                    SLT:     row.exp_val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: row.kind = KIND_NONE;
                endcase
            end
            ADDI: row.exp_val = addr;
            SLTI: row.exp_val = ($signed(a) < $signed(sign_ext(word[15:0]))) ? 32'd1 : 32'd0;
            ANDI: row.exp_val = a & zero_ext(word[15:0]);
            ORI:  row.exp_val = a | zero_ext(word[15:0]);
            LW:   row.exp_val = model_mem[addr[ADDR_BITS + 1 : 2]];
            SW: begin
                row.kind = KIND_STORE;
                row.exp_val = addr;
                row.exp_data = b;
                model_mem[addr[ADDR_BITS + 1 : 2]] = b;
            end
            default: row.kind = KIND_NONE;
        endcase
        // Register zero stays zero and shows nothing on the writeback port.
        if (row.kind == KIND_WB) begin
            if (row.exp_reg == '0) begin
                row.kind = KIND_NONE;
            end else begin
                model_regs[row.exp_reg] = row.exp_val;
            end
        end
    endtask

    //////////////////////////////
    // Program table.
    //////////////////////////////
    task automatic add_instr(input instr_t word, input int pad);
        row_t row;
        model_exec(word, row);
        row.instr = word;
        row.valid = 1'b1;
        row.enable = 1'b1;
        rows.push_back(row);
        add_idle('0, 1'b0, 1'b1, pad);
    endtask

    task automatic add_idle(input instr_t word, input logic valid, input logic enable,
                            input int count);
        row_t row;
        row.instr = word;
        row.valid = valid;
        row.enable = enable;
        row.kind = KIND_NONE;
        row.exp_reg = '0;
        row.exp_val = '0;
        row.exp_data = '0;
        for (int i = 0; i < count; i++) begin
            rows.push_back(row);
        end
    endtask

    task automatic build_program();
        imm_t imm_a;
        imm_t imm_b;
        imm_t imm_c;
        imm_t imm_d;
        imm_t imm_e;
        next_random_imm(imm_a);
        next_random_imm(imm_b);
        next_random_imm(imm_c);
        next_random_imm(imm_d);
        next_random_imm(imm_e);
        // r1 is positive and r2 negative so slt compares across the sign.
        imm_a = imm_a & 16'h7FFF;
        imm_b = imm_b | 16'h8000;
        // A set high bit tells zero extension from sign extension for ori and andi.
        imm_c = imm_c | 16'h8000;
        imm_d = imm_d | 16'h8000;

        // Bubbles and unknown encodings.
        add_idle('0, 1'b0, 1'b1, 3);
        add_instr({6'h3F, 26'd0}, 2);
        add_instr(encode_r(6'h01, 5'd1, 5'd2, 5'd3), 2);

        add_instr(encode_i(ADDI, 5'd0, 5'd1, imm_a), 2);
        add_instr(encode_i(ADDI, 5'd0, 5'd2, imm_b), 2);
        add_instr(encode_i(ORI, 5'd0, 5'd3, imm_c), 2);
        add_instr(encode_i(ANDI, 5'd2, 5'd4, imm_d), 2);
        add_instr(encode_i(SLTI, 5'd1, 5'd5, imm_e), 2);
        add_instr(encode_i(SLTI, 5'd2, 5'd23, imm_a), 2);
        add_instr(encode_r(ADD, 5'd1, 5'd2, 5'd6), 2);
        add_instr(encode_r(SUB, 5'd1, 5'd2, 5'd7), 2);
        add_instr(encode_r(AND, 5'd1, 5'd3, 5'd8), 2);
        add_instr(encode_r(OR, 5'd2, 5'd3, 5'd9), 2);
        add_instr(encode_r(NOR, 5'd1, 5'd2, 5'd10), 2);
        add_instr(encode_r(SLT, 5'd1, 5'd2, 5'd11), 2);
        add_instr(encode_r(SLT, 5'd2, 5'd1, 5'd12), 2);

        // Wraparound.
        add_instr(encode_i(ADDI, 5'd0, 5'd16, 16'h8000), 2);
        add_instr(encode_r(ADD, 5'd16, 5'd16, 5'd17), 2);
        add_instr(encode_r(SUB, 5'd0, 5'd1, 5'd15), 2);

        // Freeze the pipe with two results in flight.
        add_instr(encode_r(ADD, 5'd6, 5'd7, 5'd24), 0);
        add_idle(encode_i(ADDI, 5'd0, 5'd25, 16'h0BAD), 1'b1, 1'b0, 4);
        add_instr(encode_r(OR, 5'd8, 5'd9, 5'd26), 1);
        add_idle(encode_i(ADDI, 5'd0, 5'd25, 16'h0BAD), 1'b1, 1'b0, 3);
        add_idle('0, 1'b0, 1'b1, 2);

        // Stores and loads around a base of 0x40.
        add_instr(encode_i(ORI, 5'd0, 5'd18, 16'h0040), 2);
        add_instr(encode_i(SW, 5'd18, 5'd17, 16'h0008), 2);
        add_instr(encode_i(SW, 5'd18, 5'd7, 16'hFFFC), 2);
        add_instr(encode_i(LW, 5'd18, 5'd19, 16'h0008), 2);
        add_instr(encode_i(LW, 5'd18, 5'd20, 16'hFFFC), 2);
        add_instr(encode_i(LW, 5'd18, 5'd27, 16'h0010), 2);

        // Register zero.
        add_instr(encode_i(ADDI, 5'd0, 5'd0, 16'h0005), 2);
        add_instr(encode_r(ADD, 5'd0, 5'd0, 5'd21), 2);
        add_instr(encode_r(OR, 5'd0, 5'd1, 5'd22), 2);
    endtask

    //////////////////////////////
    // Checks.
    //////////////////////////////
    task automatic check_wb(input reg_idx_t exp_reg, input word_t exp_data);
        if ((wb_reg !== exp_reg) || (wb_data !== exp_data)) begin
            wb_errors++;
            $display("FAILED at %0t: writeback r%0d = %h, expected r%0d = %h",
                     $time, wb_reg, wb_data, exp_reg, exp_data);
        end
    endtask

    task automatic check_store(input word_t exp_addr, input word_t exp_data);
        if ((store_addr !== exp_addr) || (store_data !== exp_data)) begin
            store_errors++;
            $display("FAILED at %0t: store [%h] = %h, expected [%h] = %h",
                     $time, store_addr, store_data, exp_addr, exp_data);
        end
    endtask

    task automatic check_latency(input string port, input int exp_edges, input int got_edges);
        if (got_edges != exp_edges) begin
            latency_errors++;
            $display("FAILED at %0t: %s result after %0d enabled edges, expected %0d",
                     $time, port, got_edges, exp_edges);
        end
    endtask

    task automatic queue_expected(input row_t row, input int edge_idx);
        case (row.kind)
            KIND_WB:    wb_q.push_back(wb_exp_t'{row.exp_reg, row.exp_val, edge_idx});
            KIND_STORE: store_q.push_back(store_exp_t'{row.exp_val, row.exp_data, edge_idx});
            default:    ;
        endcase
    endtask

    // Acceptance is seen with the values presented before the edge.
    always @(posedge clock) begin
        if (soft_reset && enable_pipeline) begin
            edge_count = edge_count + 1;
            last_enabled = 1'b1;
            if (cur_row >= 0) begin
                queue_expected(rows[cur_row], edge_count);
            end
        end else begin
            last_enabled = 1'b0;
        end
    end

    // Outputs only change on an enabled edge, so held values are not counted twice.
    always @(negedge clock) begin
        if (soft_reset && last_enabled) begin
            if (wb_valid) begin
                if (wb_q.size() == 0) begin
                    wb_errors++;
                    $display("Unexpected writeback to r%0d at %0t with nothing pending",
                             wb_reg, $time);
                end else begin
                    wb_head = wb_q.pop_front();
                    check_wb(wb_head.dest, wb_head.data);
                    check_latency("writeback", WB_DELAY, edge_count - wb_head.edge_idx);
                end
            end
            if (store_valid) begin
                if (store_q.size() == 0) begin
                    store_errors++;
                    $display("Unexpected store to %h at %0t with nothing pending",
                             store_addr, $time);
                end else begin
                    store_head = store_q.pop_front();
                    check_store(store_head.addr, store_head.data);
                    check_latency("store", STORE_DELAY, edge_count - store_head.edge_idx);
                end
            end
        end
    end

    //////////////////////////////
    // Main sequence.
    //////////////////////////////
    initial begin
        soft_reset = 1'b0;
        enable_pipeline = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        cur_row = -1;
        edge_count = 0;
        last_enabled = 1'b0;
        wb_errors = 0;
        store_errors = 0;
        latency_errors = 0;
        missing_errors = 0;
        lfsr_state = LFSR_SEED;
        for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < `MIPS_DMEM_DEPTH; i++) begin
            model_mem[i] = '0;
        end
        build_program();

        repeat (2) @(posedge clock);
        soft_reset <= 1'b1;
        foreach (rows[r]) begin
            @(posedge clock);
            instr <= rows[r].instr;
            instr_valid <= rows[r].valid;
            enable_pipeline <= rows[r].enable;
            cur_row <= r;
        end
        @(posedge clock);
        instr <= '0;
        instr_valid <= 1'b0;
        enable_pipeline <= 1'b1;
        cur_row <= -1;

        @(negedge clock);
        wait_cycles = 0;
        while (((wb_q.size() + store_q.size()) > 0) && (wait_cycles < DRAIN_LIMIT)) begin
            @(negedge clock);
            wait_cycles++;
        end
        if ((wb_q.size() + store_q.size()) > 0) begin
            missing_errors = wb_q.size() + store_q.size();
            $display("Results went missing: %0d writebacks and %0d stores never appeared",
                     wb_q.size(), store_q.size());
        end
        // A few idle cycles catch any late extra event.
        repeat (4) @(negedge clock);

        $display("Errors: writeback %0d, store %0d, latency %0d, missing %0d",
                 wb_errors, store_errors, latency_errors, missing_errors);
        if ((wb_errors + store_errors + latency_errors + missing_errors) == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
